/* hdl/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;     // data, pc and instruction word
    typedef logic [4:0]  regaddr_t;  // register index

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS2   // lui, result is operand 2
    } alu_mode_t;

    typedef enum logic [1:0] {
        MA_X,       // no access
        MA_LOAD,
        MA_STORE
    } ma_mode_t;

    typedef enum logic [1:0] {
        WB_SRC_NONE,
        WB_SRC_ALU,
        WB_SRC_MEM
    } wb_src_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_IMM   = 7'b0010011,
        OP_STORE = 7'b0100011,
        OP_REG   = 7'b0110011,
        OP_LUI   = 7'b0110111
    } opcode_t;

    // bubble values
    localparam word_t    NOP_PC      = 32'hFFFF_FFFF;
    localparam word_t    NOP_IR      = 32'h0000_0013;  // addi x0, x0, 0
    localparam ma_mode_t NOP_MA_MODE = MA_X;
    localparam wb_src_t  NOP_WB_SRC  = WB_SRC_NONE;

    // funct3 codes for alu ops
    localparam logic [2:0] F3_ADD  = 3'b000;  // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // srl and sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 for lw and sw
    localparam logic [2:0] F3_WORD = 3'b010;

    // funct7 codes
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra, srai

endpackage

/* hdl/regfile.sv */
`timescale 1ns/1ns

module regfile (
    input  logic              clk_i,
    input  logic              reset_i,
    input  cpu_pkg::regaddr_t rs1_addr_i,
    input  cpu_pkg::regaddr_t rs2_addr_i,
    output cpu_pkg::word_t    rs1_data_o,
    output cpu_pkg::word_t    rs2_data_o,
    input  logic              we_i,
    input  cpu_pkg::regaddr_t wr_addr_i,
    input  cpu_pkg::word_t    wr_data_i
);
    import cpu_pkg::*;

    word_t regs [32];
    logic  wr_en;

    assign wr_en = we_i && wr_addr_i != '0;  // x0 stays zero

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // same-cycle write is visible to decode
    assign rs1_data_o = (wr_en && wr_addr_i == rs1_addr_i) ? wr_data_i : regs[rs1_addr_i];
    assign rs2_data_o = (wr_en && wr_addr_i == rs2_addr_i) ? wr_data_i : regs[rs2_addr_i];

    a_x0_reads_zero: assert property (@(posedge clk_i) disable iff (reset_i)
        (rs1_addr_i == '0 |-> rs1_data_o == '0) and (rs2_addr_i == '0 |-> rs2_data_o == '0));

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ns

module alu (
    input  cpu_pkg::alu_mode_t alu_mode_i,
    input  cpu_pkg::word_t     alu_op1_i,
    input  cpu_pkg::word_t     alu_op2_i,
    output cpu_pkg::word_t     alu_result_o
);
    import cpu_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = alu_op2_i[4:0];
    assign lt_signed   = $signed(alu_op1_i) < $signed(alu_op2_i);
    assign lt_unsigned = alu_op1_i < alu_op2_i;

    always_comb begin
        case (alu_mode_i)
            ALU_ADD:   alu_result_o = alu_op1_i + alu_op2_i;
            ALU_SUB:   alu_result_o = alu_op1_i - alu_op2_i;
            ALU_AND:   alu_result_o = alu_op1_i & alu_op2_i;
            ALU_OR:    alu_result_o = alu_op1_i | alu_op2_i;
            ALU_XOR:   alu_result_o = alu_op1_i ^ alu_op2_i;
            ALU_SLT:   alu_result_o = {31'b0, lt_signed};
            ALU_SLTU:  alu_result_o = {31'b0, lt_unsigned};
            ALU_SLL:   alu_result_o = alu_op1_i << shamt;
            ALU_SRL:   alu_result_o = alu_op1_i >> shamt;
            ALU_SRA:   alu_result_o = $signed(alu_op1_i) >>> shamt;  // sign fill
            ALU_PASS2: alu_result_o = alu_op2_i;
            default:   alu_result_o = '0;
        endcase
    end

endmodule

/* hdl/stage_decode.sv */
`timescale 1ns/1ns

module stage_decode (
    input  logic               clk_i,
    input  logic               reset_i,
    input  cpu_pkg::word_t     pc_i,
    input  cpu_pkg::word_t     ir_i,
    input  cpu_pkg::word_t     rs1_data_i,
    input  cpu_pkg::word_t     rs2_data_i,
    output cpu_pkg::regaddr_t  rs1_addr_o,
    output cpu_pkg::regaddr_t  rs2_addr_o,
    output cpu_pkg::word_t     pc_o,
    output cpu_pkg::word_t     ir_o,
    output cpu_pkg::word_t     alu_op1_o,
    output cpu_pkg::word_t     alu_op2_o,
    output cpu_pkg::alu_mode_t alu_mode_o,
    output cpu_pkg::ma_mode_t  ma_mode_o,
    output cpu_pkg::word_t     ma_data_o,
    output cpu_pkg::wb_src_t   wb_src_o,
    output cpu_pkg::regaddr_t  wb_addr_o,
    output logic               wb_valid_o,
    output logic               illegal_o,
    output logic               empty_o
);
    import cpu_pkg::*;

    logic [2:0] funct3;
    logic       f7_base;
    logic       f7_alt;
    regaddr_t   rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;
    word_t      op2;
    alu_mode_t  alu_mode;
    ma_mode_t   ma_mode;
    wb_src_t    wb_src;
    logic       legal;
    logic       bubble;

    function automatic alu_mode_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign funct3     = ir_i[14:12];
    assign f7_base    = ir_i[31:25] == F7_BASE;
    assign f7_alt     = ir_i[31:25] == F7_ALT;
    assign rd         = ir_i[11:7];
    assign rs1_addr_o = ir_i[19:15];
    assign rs2_addr_o = ir_i[24:20];
    assign imm_i      = {{20{ir_i[31]}}, ir_i[31:20]};
    assign imm_s      = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    assign imm_u      = {ir_i[31:12], 12'b0};
    assign bubble     = pc_i == NOP_PC;

    always_comb begin
        alu_mode = ALU_ADD;
        ma_mode  = NOP_MA_MODE;
        wb_src   = NOP_WB_SRC;
        op2      = imm_i;
        legal    = 1'b1;
        case (ir_i[6:0])
            OP_REG: begin
                op2      = rs2_data_i;
                wb_src   = WB_SRC_ALU;
                alu_mode = alu_sel(funct3, ir_i[30]);
                legal    = f7_base || (f7_alt && (funct3 == F3_ADD || funct3 == F3_SR));
            end
            OP_IMM: begin
                wb_src   = WB_SRC_ALU;
                alu_mode = alu_sel(funct3, funct3 == F3_SR && f7_alt);  // addi has no sub form
                if (funct3 == F3_SLL) legal = f7_base;
                else if (funct3 == F3_SR) legal = f7_base || f7_alt;
            end
            OP_LUI: begin
                op2      = imm_u;
                wb_src   = WB_SRC_ALU;
                alu_mode = ALU_PASS2;
            end
            OP_LOAD: begin
                ma_mode = MA_LOAD;
                wb_src  = WB_SRC_MEM;
                legal   = funct3 == F3_WORD;
            end
            OP_STORE: begin
                op2     = imm_s;
                ma_mode = MA_STORE;
                legal   = funct3 == F3_WORD;
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || bubble || !legal) begin  // bad words leave as bubbles
            pc_o       <= NOP_PC;
            ir_o       <= NOP_IR;
            alu_mode_o <= ALU_ADD;
            ma_mode_o  <= NOP_MA_MODE;
            wb_src_o   <= NOP_WB_SRC;
            wb_valid_o <= 1'b0;
        end else begin
            pc_o       <= pc_i;
            ir_o       <= ir_i;
            alu_mode_o <= alu_mode;
            ma_mode_o  <= ma_mode;
            wb_src_o   <= wb_src;
            wb_valid_o <= wb_src != WB_SRC_NONE && rd != '0;
        end
        illegal_o <= !reset_i && !bubble && !legal;
    end

    always_ff @(posedge clk_i) begin
        alu_op1_o <= rs1_data_i;
        alu_op2_o <= op2;
        ma_data_o <= rs2_data_i;  // store data
        wb_addr_o <= rd;
    end

    assign empty_o = pc_o == NOP_PC;

    a_illegal_is_bubble: assert property (@(posedge clk_i) disable iff (reset_i)
        illegal_o |-> pc_o == NOP_PC && !wb_valid_o && ma_mode_o == MA_X);

endmodule

/* hdl/stage_execute.sv */
`timescale 1ns/1ns

module stage_execute (
    input  logic               clk_i,
    input  logic               reset_i,
    input  cpu_pkg::word_t     pc_i,
    input  cpu_pkg::word_t     ir_i,
    input  cpu_pkg::word_t     alu_op1_i,
    input  cpu_pkg::word_t     alu_op2_i,
    input  cpu_pkg::alu_mode_t alu_mode_i,
    input  cpu_pkg::ma_mode_t  ma_mode_i,
    input  cpu_pkg::word_t     ma_data_i,
    input  cpu_pkg::wb_src_t   wb_src_i,
    input  cpu_pkg::regaddr_t  wb_addr_i,
    input  logic               wb_valid_i,
    output cpu_pkg::word_t     pc_o,
    output cpu_pkg::word_t     ma_addr_o,
    output cpu_pkg::ma_mode_t  ma_mode_o,
    output cpu_pkg::word_t     ma_data_o,
    output cpu_pkg::wb_src_t   wb_src_o,
    output cpu_pkg::regaddr_t  wb_addr_o,
    output cpu_pkg::word_t     wb_data_o,
    output logic               wb_valid_o,
    output logic               empty_o
);
    import cpu_pkg::*;

    word_t alu_result;

    alu i_alu (
        .alu_mode_i   (alu_mode_i),
        .alu_op1_i    (alu_op1_i),
        .alu_op2_i    (alu_op2_i),
        .alu_result_o (alu_result)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_o       <= NOP_PC;
            ma_mode_o  <= NOP_MA_MODE;
            wb_src_o   <= NOP_WB_SRC;
            wb_valid_o <= 1'b0;
        end else begin
            pc_o       <= pc_i;
            ma_mode_o  <= ma_mode_i;
            wb_src_o   <= wb_src_i;
            wb_valid_o <= wb_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        ma_addr_o <= (ma_mode_i == MA_X) ? '0 : alu_result;  // effective address
        ma_data_o <= ma_data_i;
        wb_addr_o <= wb_addr_i;
        wb_data_o <= (wb_src_i == WB_SRC_ALU) ? alu_result : '0;  // loads fill in later
    end

    assign empty_o = pc_o == NOP_PC;

    a_load_from_mem: assert property (@(posedge clk_i) disable iff (reset_i)
        ma_mode_i == MA_LOAD |-> wb_src_i == WB_SRC_MEM && ir_i[6:0] == OP_LOAD);

    a_store_no_wb: assert property (@(posedge clk_i) disable iff (reset_i)
        ma_mode_i == MA_STORE |-> !wb_valid_i && ir_i[6:0] == OP_STORE);

endmodule

/* hdl/stage_memory.sv */
`timescale 1ns/1ns

module stage_memory #(
    parameter int DMEM_WORDS = 64
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  cpu_pkg::word_t    pc_i,
    input  cpu_pkg::word_t    ma_addr_i,
    input  cpu_pkg::ma_mode_t ma_mode_i,
    input  cpu_pkg::word_t    ma_data_i,
    input  cpu_pkg::wb_src_t  wb_src_i,
    input  cpu_pkg::regaddr_t wb_addr_i,
    input  cpu_pkg::word_t    wb_data_i,
    input  logic              wb_valid_i,
    output logic              wb_valid_o,
    output cpu_pkg::regaddr_t wb_addr_o,
    output cpu_pkg::word_t    wb_data_o,
    output logic              empty_o
);
    import cpu_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);
    localparam int ROW_W = IDX_W - 2;  // four words cleared per cycle

    word_t            mem [DMEM_WORDS];
    logic [ROW_W-1:0] clr_row;
    logic [IDX_W-1:0] idx;
    word_t            pc_r;

    assign idx = ma_addr_i[IDX_W+1:2];  // word index

    // walks the ram during reset, parked at row 0 otherwise
    always_ff @(posedge clk_i) begin
        if (reset_i) clr_row <= clr_row + 1'b1;
        else clr_row <= '0;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int k = 0; k < 4; k++) begin
                mem[{clr_row, 2'(k)}] <= '0;
            end
        end else if (ma_mode_i == MA_STORE) begin
            mem[idx] <= ma_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_r       <= NOP_PC;
            wb_valid_o <= 1'b0;
        end else begin
            pc_r       <= pc_i;
            wb_valid_o <= wb_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_addr_o <= wb_addr_i;
        wb_data_o <= (wb_src_i == WB_SRC_MEM) ? mem[idx] : wb_data_i;  // load data
    end

    assign empty_o = pc_r == NOP_PC;

    a_word_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        ma_mode_i != MA_X |-> ma_addr_i[1:0] == 2'b00);

    a_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
        ma_mode_i != MA_X |-> ma_addr_i < 32'(DMEM_WORDS * 4));

endmodule

/* hdl/cpu_core.sv */
`timescale 1ns/1ns

module cpu_core #(
    parameter int DMEM_WORDS = 64
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  cpu_pkg::word_t    pc_i,
    input  cpu_pkg::word_t    ir_i,
    output logic              wb_valid_o,
    output cpu_pkg::regaddr_t wb_addr_o,
    output cpu_pkg::word_t    wb_data_o,
    output logic              illegal_o,
    output logic              empty_o
);
    import cpu_pkg::*;

    // register file read side
    regaddr_t  rs1_addr;
    regaddr_t  rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    // decode to execute
    word_t     de_pc;
    word_t     de_ir;
    word_t     de_alu_op1;
    word_t     de_alu_op2;
    alu_mode_t de_alu_mode;
    ma_mode_t  de_ma_mode;
    word_t     de_ma_data;
    wb_src_t   de_wb_src;
    regaddr_t  de_wb_addr;
    logic      de_wb_valid;
    logic      de_empty;

    // execute to memory
    word_t     ex_pc;
    word_t     ex_ma_addr;
    ma_mode_t  ex_ma_mode;
    word_t     ex_ma_data;
    wb_src_t   ex_wb_src;
    regaddr_t  ex_wb_addr;
    word_t     ex_wb_data;
    logic      ex_wb_valid;
    logic      ex_empty;

    logic      mem_empty;

    regfile i_regfile (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_valid_o),  // written from the memory stage
        .wr_addr_i  (wb_addr_o),
        .wr_data_i  (wb_data_o)
    );

    stage_decode i_decode (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .pc_i       (pc_i),
        .ir_i       (ir_i),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .pc_o       (de_pc),
        .ir_o       (de_ir),
        .alu_op1_o  (de_alu_op1),
        .alu_op2_o  (de_alu_op2),
        .alu_mode_o (de_alu_mode),
        .ma_mode_o  (de_ma_mode),
        .ma_data_o  (de_ma_data),
        .wb_src_o   (de_wb_src),
        .wb_addr_o  (de_wb_addr),
        .wb_valid_o (de_wb_valid),
        .illegal_o  (illegal_o),
        .empty_o    (de_empty)
    );

    stage_execute i_execute (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .pc_i       (de_pc),
        .ir_i       (de_ir),
        .alu_op1_i  (de_alu_op1),
        .alu_op2_i  (de_alu_op2),
        .alu_mode_i (de_alu_mode),
        .ma_mode_i  (de_ma_mode),
        .ma_data_i  (de_ma_data),
        .wb_src_i   (de_wb_src),
        .wb_addr_i  (de_wb_addr),
        .wb_valid_i (de_wb_valid),
        .pc_o       (ex_pc),
        .ma_addr_o  (ex_ma_addr),
        .ma_mode_o  (ex_ma_mode),
        .ma_data_o  (ex_ma_data),
        .wb_src_o   (ex_wb_src),
        .wb_addr_o  (ex_wb_addr),
        .wb_data_o  (ex_wb_data),
        .wb_valid_o (ex_wb_valid),
        .empty_o    (ex_empty)
    );

    stage_memory #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_memory (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .pc_i       (ex_pc),
        .ma_addr_i  (ex_ma_addr),
        .ma_mode_i  (ex_ma_mode),
        .ma_data_i  (ex_ma_data),
        .wb_src_i   (ex_wb_src),
        .wb_addr_i  (ex_wb_addr),
        .wb_data_i  (ex_wb_data),
        .wb_valid_i (ex_wb_valid),
        .wb_valid_o (wb_valid_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o),
        .empty_o    (mem_empty)
    );

    assign empty_o = de_empty & ex_empty & mem_empty;

endmodule

/* verif/cpu_core_tb.sv */
`timescale 1ns/1ns

module cpu_core_tb;
    import cpu_pkg::*;

    localparam int DMEM_WORDS     = 64;
    localparam int IDX_W          = $clog2(DMEM_WORDS);
    localparam int RESET_CYCLES   = 16;
    localparam int DIRECTED_SLOTS = 80;  // upper bound
    localparam int RANDOM_SLOTS   = 400;
    localparam int DRAIN_SLOTS    = 6;
    localparam int TIMEOUT_CYCLES =
        2 * (RESET_CYCLES + DIRECTED_SLOTS + RANDOM_SLOTS + DRAIN_SLOTS) + 100;

    typedef logic [IDX_W-1:0] widx_t;

    logic     clk_i;
    logic     reset_i;
    word_t    pc_i;
    word_t    ir_i;
    logic     wb_valid_o;
    regaddr_t wb_addr_o;
    word_t    wb_data_o;
    logic     illegal_o;
    logic     empty_o;

    word_t       model_regs [32];
    word_t       model_mem [DMEM_WORDS];
    word_t       next_pc;
    logic [31:0] lfsr;
    regaddr_t    last_rd0;  // destination of the previous slot
    regaddr_t    last_rd1;  // and of the one before
    regaddr_t    rot;
    int          cycle_count = 0;

    // expectation for the slot now on the inputs
    logic     cur_busy;
    logic     cur_wb;
    logic     cur_illegal;
    regaddr_t cur_addr;
    word_t    cur_data;

    // one entry per pipeline stage, index 2 is the memory stage
    logic [2:0]       exp_busy;
    logic [2:0]       exp_wb;
    logic [2:0]       exp_illegal;
    logic [2:0][4:0]  exp_addr;
    logic [2:0][31:0] exp_data;

    cpu_core #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_dut (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .pc_i       (pc_i),
        .ir_i       (ir_i),
        .wb_valid_o (wb_valid_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o),
        .illegal_o  (illegal_o),
        .empty_o    (empty_o)
    );

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t want);
        stop_on_error($sformatf("Mismatch %s: got %h expected %h", name, got, want));
    endtask

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // x^32+x^22+x^2+x+1
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic regaddr_t draw_reg();
        return regaddr_t'(take_bits(4) % 32'd15 + 32'd1);  // x1 to x15
    endfunction

    function automatic logic is_recent(input regaddr_t r);
        return r == last_rd0 || r == last_rd1;
    endfunction

    function automatic regaddr_t fresh_dest();
        rot = (rot == 5'd15) ? 5'd4 : rot + 5'd1;
        return rot;
    endfunction

    // rv32i semantics by funct3, alt selects sub and sra
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return (a >> sh) | ((alt && a[31]) ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic issue_slot(input word_t pc, input word_t ir, input logic busy,
                              input logic wb, input regaddr_t rd, input word_t data,
                              input logic illegal);
        @(negedge clk_i);
        pc_i        = pc;
        ir_i        = ir;
        cur_busy    = busy;
        cur_wb      = wb;
        cur_addr    = rd;
        cur_data    = data;
        cur_illegal = illegal;
        last_rd1    = last_rd0;
        last_rd0    = wb ? rd : 5'd0;
    endtask

    task automatic bubble();
        issue_slot(NOP_PC, NOP_IR, 1'b0, 1'b0, 5'd0, 32'd0, 1'b0);
    endtask

    task automatic bad_word(input word_t ir);
        issue_slot(next_pc, ir, 1'b0, 1'b0, 5'd0, 32'd0, 1'b1);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic retire(input word_t ir, input regaddr_t rd, input word_t data);
        if (rd != 5'd0) model_regs[rd] = data;
        issue_slot(next_pc, ir, 1'b1, rd != 5'd0, rd, data, 1'b0);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic exec_reg(input logic [2:0] f3, input logic alt, input regaddr_t rd,
                            input regaddr_t rs1, input regaddr_t rs2);
        word_t ir;
        ir = {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, OP_REG};
        retire(ir, rd, alu_ref(f3, alt, model_regs[rs1], model_regs[rs2]));
    endtask

    task automatic exec_imm(input logic [2:0] f3, input logic alt, input regaddr_t rd,
                            input regaddr_t rs1, input logic [11:0] imm);
        logic [11:0] field;
        logic        sra;
        sra   = f3 == 3'b101 && alt;
        field = imm;
        if (f3 == 3'b001 || f3 == 3'b101) begin
            field = {sra ? 7'b0100000 : 7'b0000000, imm[4:0]};  // shift amount form
        end
        retire({field, rs1, f3, rd, OP_IMM}, rd,
               alu_ref(f3, sra, model_regs[rs1], {{20{field[11]}}, field}));
    endtask

    task automatic exec_lui(input regaddr_t rd, input logic [19:0] imm20);
        retire({imm20, rd, OP_LUI}, rd, {imm20, 12'h000});
    endtask

    task automatic exec_load(input regaddr_t rd, input widx_t w);
        retire({12'({w, 2'b00}), 5'd0, F3_WORD, rd, OP_LOAD}, rd, model_mem[w]);
    endtask

    task automatic exec_store(input regaddr_t rs2, input widx_t w);
        logic [11:0] a;
        a = 12'({w, 2'b00});
        model_mem[w] = model_regs[rs2];
        issue_slot(next_pc, {a[11:5], rs2, 5'd0, F3_WORD, a[4:0], OP_STORE},
                   1'b1, 1'b0, 5'd0, 32'd0, 1'b0);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic run_directed();
        exec_lui(5'd1, 20'h80000);
        exec_imm(F3_ADD, 1'b0, 5'd2, 5'd0, 12'hFFB);  // -5
        exec_imm(F3_ADD, 1'b0, 5'd3, 5'd0, 12'h007);
        bubble();
        bubble();
        for (int f = 0; f < 8; f++) begin  // sources never rewritten, so back to back
            exec_reg(3'(f), 1'b0, fresh_dest(), 5'd2, 5'd3);
            exec_reg(3'(f), 1'b0, fresh_dest(), 5'd3, 5'd1);
            exec_imm(3'(f), 1'b0, fresh_dest(), 5'd2, 12'hFF9);
        end
        exec_reg(F3_ADD, 1'b1, fresh_dest(), 5'd2, 5'd3);  // sub
        exec_reg(F3_ADD, 1'b1, fresh_dest(), 5'd3, 5'd2);
        exec_reg(F3_SR, 1'b1, fresh_dest(), 5'd1, 5'd3);   // sra
        exec_reg(F3_SR, 1'b1, fresh_dest(), 5'd2, 5'd3);
        exec_imm(F3_SR, 1'b1, fresh_dest(), 5'd1, 12'h004);
        exec_imm(F3_ADD, 1'b0, 5'd0, 5'd3, 12'h123);  // x0 target
        exec_lui(5'd0, 20'hABCDE);
        bubble();
        bubble();
        exec_reg(F3_OR, 1'b0, 5'd4, 5'd0, 5'd0);
        exec_imm(F3_ADD, 1'b0, 5'd5, 5'd2, 12'h064);
        bubble();
        bubble();
        exec_reg(F3_ADD, 1'b0, 5'd6, 5'd5, 5'd3);  // exactly three slots after x5
        bubble();
        bubble();
        exec_store(5'd6, widx_t'(4));
        exec_store(5'd1, widx_t'(DMEM_WORDS - 1));
        bubble();
        exec_load(5'd7, widx_t'(4));
        exec_load(5'd8, widx_t'(DMEM_WORDS - 1));
        exec_load(5'd9, widx_t'(10));  // never written
        bubble();
        exec_reg(F3_ADD, 1'b0, 5'd10, 5'd7, 5'd8);
        bad_word(32'h0000_007F);
        bad_word({7'b0000010, 5'd1, 5'd2, 3'b000, 5'd3, OP_REG});
        bad_word({7'b0100000, 5'd3, 5'd1, 3'b001, 5'd4, OP_IMM});
        bad_word({12'd0, 5'd0, 3'b000, 5'd4, OP_LOAD});  // lb
        repeat (4) bubble();
    endtask

    task automatic random_slot();
        logic [2:0] kind;
        logic [2:0] f3;
        logic       alt;
        regaddr_t   rd;
        regaddr_t   rs1;
        regaddr_t   rs2;
        kind = 3'(take_bits(3));
        f3   = 3'(take_bits(3));
        alt  = 1'(take_bits(1)) && (f3 == 3'b000 || f3 == 3'b101);
        rd   = draw_reg();
        rs1  = draw_reg();
        rs2  = draw_reg();
        case (kind)
            3'd0, 3'd1, 3'd2: begin
                if (is_recent(rs1) || is_recent(rs2)) bubble();
                else exec_reg(f3, alt, rd, rs1, rs2);
            end
            3'd3, 3'd4: begin
                if (is_recent(rs1)) bubble();
                else exec_imm(f3, alt, rd, rs1, 12'(take_bits(12)));
            end
            3'd5: exec_lui(rd, 20'(take_bits(20)));
            3'd6: exec_load(rd, widx_t'(take_bits(IDX_W)));
            default: begin
                if (is_recent(rs2)) bubble();
                else exec_store(rs2, widx_t'(take_bits(IDX_W)));
            end
        endcase
    endtask

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        if (reset_i) begin
            exp_busy    <= '0;
            exp_wb      <= '0;
            exp_illegal <= '0;
            exp_addr    <= '0;
            exp_data    <= '0;
        end else begin
            exp_busy    <= {exp_busy[1:0], cur_busy};
            exp_wb      <= {exp_wb[1:0], cur_wb};
            exp_illegal <= {exp_illegal[1:0], cur_illegal};
            exp_addr    <= {exp_addr[1:0], cur_addr};
            exp_data    <= {exp_data[1:0], cur_data};
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("Timeout: test did not end within %0d cycles",
                                    TIMEOUT_CYCLES));
        end
    end

    a_wb_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_valid_o == exp_wb[2])
        else report_mismatch("wb_valid_o", 32'($sampled(wb_valid_o)), 32'($sampled(exp_wb[2])));

    a_wb_addr: assert property (@(posedge clk_i) disable iff (reset_i)
        exp_wb[2] |-> wb_addr_o == exp_addr[2])
        else report_mismatch("wb_addr_o", 32'($sampled(wb_addr_o)), 32'($sampled(exp_addr[2])));

    a_wb_data: assert property (@(posedge clk_i) disable iff (reset_i)
        exp_wb[2] |-> wb_data_o == exp_data[2])
        else report_mismatch("wb_data_o", $sampled(wb_data_o), $sampled(exp_data[2]));

    a_illegal: assert property (@(posedge clk_i) disable iff (reset_i)
        illegal_o == exp_illegal[0])  // one cycle after issue
        else report_mismatch("illegal_o", 32'($sampled(illegal_o)),
                             32'($sampled(exp_illegal[0])));

    a_empty: assert property (@(posedge clk_i) disable iff (reset_i)
        empty_o == (exp_busy == 3'b000))
        else report_mismatch("empty_o", 32'($sampled(empty_o)),
                             32'($sampled(exp_busy) == 3'b000));

    initial begin
        reset_i     = 1'b1;
        pc_i        = NOP_PC;
        ir_i        = NOP_IR;
        cur_busy    = 1'b0;
        cur_wb      = 1'b0;
        cur_illegal = 1'b0;
        cur_addr    = 5'd0;
        cur_data    = 32'd0;
        model_regs  = '{default: '0};
        model_mem   = '{default: '0};
        lfsr        = 32'h4f851c6f;
        next_pc     = 32'd0;
        last_rd0    = 5'd0;
        last_rd1    = 5'd0;
        rot         = 5'd3;
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_i = 1'b0;
        repeat (2) bubble();
        run_directed();
        repeat (RANDOM_SLOTS) random_slot();
        repeat (DRAIN_SLOTS) bubble();  // last retirements and empty pipeline
        $display(">>> PASS");
        $finish;
    end

endmodule

/* build.f */
hdl/cpu_pkg.sv
hdl/regfile.sv
hdl/alu.sv
hdl/stage_decode.sv
hdl/stage_execute.sv
hdl/stage_memory.sv
hdl/cpu_core.sv
verif/cpu_core_tb.sv

/* run.sh */
#!/bin/sh
# compile with verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" \
    && verilator --binary --assert --timing -f build.f --top-module cpu_core_tb -o sim_cpu \
    && ./obj_dir/sim_cpu | grep -Fx '>>> PASS' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
